// ==== Bender.yml ====
package:
  name: int_pipe

sources:
  - files:
      - design/pipePkg.sv
      - design/instrDecode.sv
      - design/regFile.sv
      - design/intAlu.sv
      - design/hazardUnit.sv
      - design/dataMem.sv
      - design/intPipe.sv
  - target: test
    files:
      - dv/intPipeTb.sv

// ==== design/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem import pipePkg::*; (
  input  logic            clk,
  input  logic            We,
  input  logic [xlen-1:0] Addr,
  input  logic [xlen-1:0] Wd,
  output logic [xlen-1:0] Rd
);

  logic [xlen-1:0]     mem [memWords] = '{default: '0};
  logic [memAddrW-1:0] wordIdx;

  // Drop the byte offset, upper address bits wrap around the array
  assign wordIdx = Addr[memAddrW+1:2];

  always_ff @(posedge clk) begin
    if (We) begin
      mem[wordIdx] <= Wd;
    end
  end

  // Read is combinational, a write at this edge shows up next cycle
  assign Rd = mem[wordIdx];

  // Only word stores exist, so the low address bits of a write must be zero
  aWordAligned: assert property (@(posedge clk) We |-> (Addr[1:0] == 2'b00))
    else $error("misaligned store address %h", Addr);

endmodule

`default_nettype wire

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import pipePkg::*; (
  // Register numbers of the Decode, Execute, Memory and Writeback stages
  input  logic [regAddrW-1:0] Rs1D, Rs2D, Rs1E, Rs2E, RdE, RdM, RdW,
  input  logic                MemReadE,
  input  logic                RegWriteM, RegWriteW,
  // Bypass selects for the two Execute operands
  output fwdSelT              ForwardAE, ForwardBE,
  output logic                LoadStallD
);

  logic matchDE;

  // Memory holds the younger result and wins when both write the same rd
  function automatic fwdSelT pickFwd(
    input logic [regAddrW-1:0] rs,
    input logic [regAddrW-1:0] rdM,
    input logic [regAddrW-1:0] rdW,
    input logic                wrM,
    input logic                wrW
  );
    fwdSelT sel;
    sel = fwdNone;
    if (rs != '0) begin
      if ((rs == rdM) && wrM) sel = fwdM;
      else if ((rs == rdW) && wrW) sel = fwdW;
    end
    return sel;
  endfunction

  assign ForwardAE = pickFwd(Rs1E, RdM, RdW, RegWriteM, RegWriteW);
  assign ForwardBE = pickFwd(Rs2E, RdM, RdW, RegWriteM, RegWriteW);

  // A load's data only exists at the end of Memory and comes too late for the
  // instruction directly behind it, which therefore waits a cycle in Decode
  assign matchDE = (Rs1D == RdE) || (Rs2D == RdE);
  assign LoadStallD = MemReadE && matchDE;

endmodule

`default_nettype wire

// ==== design/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode import pipePkg::*; (
  input  instrU   Instr,
  input  logic    InstrValid,
  output decCtrlT Ctrl
);

  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;

  // Sign-extended immediates for both immediate formats
  assign immI = {{(xlen-12){Instr.iType.imm12[11]}}, Instr.iType.imm12};
  assign immS = {{(xlen-12){Instr.sType.immHi[6]}}, Instr.sType.immHi, Instr.sType.immLo};

  always_comb begin
    // Start from a bubble and only turn on what a legal instruction needs
    Ctrl = '0;
    if (InstrValid) begin
      case (Instr.rType.opcode)
        opOp: begin
          Ctrl.regWrite = 1'b1;
          Ctrl.rd = Instr.rType.rd;
          Ctrl.rs1 = Instr.rType.rs1;
          Ctrl.rs2 = Instr.rType.rs2;
          case ({Instr.rType.funct7, Instr.rType.funct3})
            {f7Base, f3AddSub}: Ctrl.aluOp = aluAdd;
            {f7Sub, f3AddSub}:  Ctrl.aluOp = aluSub;
            {f7Base, f3Slt}:    Ctrl.aluOp = aluSlt;
            {f7Base, f3Xor}:    Ctrl.aluOp = aluXor;
            {f7Base, f3Or}:     Ctrl.aluOp = aluOr;
            {f7Base, f3And}:    Ctrl.aluOp = aluAnd;
            // Other R-type functions are not implemented
            default: Ctrl = '0;
          endcase
        end
        opOpImm: begin
          // Only ADDI is present in the immediate ALU group
          if (Instr.iType.funct3 == f3AddSub) begin
            Ctrl.regWrite = 1'b1;
            Ctrl.useImm = 1'b1;
            Ctrl.rd = Instr.iType.rd;
            Ctrl.rs1 = Instr.iType.rs1;
            Ctrl.imm = immI;
          end
        end
        opLoad: begin
          // Word loads only, the address is rs1 plus the I immediate
          if (Instr.iType.funct3 == f3Word) begin
            Ctrl.regWrite = 1'b1;
            Ctrl.memRead = 1'b1;
            Ctrl.useImm = 1'b1;
            Ctrl.rd = Instr.iType.rd;
            Ctrl.rs1 = Instr.iType.rs1;
            Ctrl.imm = immI;
          end
        end
        opStore: begin
          // rs2 carries the store data and rd stays zero
          if (Instr.sType.funct3 == f3Word) begin
            Ctrl.memWrite = 1'b1;
            Ctrl.useImm = 1'b1;
            Ctrl.rs1 = Instr.sType.rs1;
            Ctrl.rs2 = Instr.sType.rs2;
            Ctrl.imm = immS;
          end
        end
        default: Ctrl = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/intAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module intAlu import pipePkg::*; (
  input  logic [xlen-1:0] A,
  input  logic [xlen-1:0] B,
  input  aluOpT           AluOp,
  output logic [xlen-1:0] Y
);

  logic lessThan;

  // Signed compare for SLT
  assign lessThan = $signed(A) < $signed(B);

  always_comb begin
    case (AluOp)
      aluAdd: Y = A + B;
      aluSub: Y = A - B;
      aluAnd: Y = A & B;
      aluOr:  Y = A | B;
      aluXor: Y = A ^ B;
      // Result is 0 or 1 in the low bit
      aluSlt: Y = {{(xlen-1){1'b0}}, lessThan};
      default: Y = A + B;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/intPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module intPipe import pipePkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  instrU               Instr,
  input  logic                InstrValid,
  output logic                StallD,
  output logic                RegWriteW,
  output logic [regAddrW-1:0] RdW,
  output logic [xlen-1:0]     ResultW
);

  instrU           instrD;
  logic            instrValidD;
  decCtrlT         ctrlD;
  logic [xlen-1:0] rd1D, rd2D;
  exStageT         exD, exE;
  fwdSelT          forwardAE, forwardBE;
  logic [xlen-1:0] srcAE, fwdBE, srcBE, aluResultE;
  memStageT        memE, memM;
  logic [xlen-1:0] readDataM;
  wbStageT         wbM, wbW;

  // Three-way operand pick between register file, Memory and Writeback
  function automatic logic [xlen-1:0] fwdMux(
    input fwdSelT          sel,
    input logic [xlen-1:0] regVal,
    input logic [xlen-1:0] memVal,
    input logic [xlen-1:0] wbVal
  );
    logic [xlen-1:0] val;
    case (sel)
      fwdM: val = memVal;
      fwdW: val = wbVal;
      default: val = regVal;
    endcase
    return val;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  // The Decode register holds while stalled and the source keeps Instr steady
  always_ff @(posedge clk) begin
    if (rst) instrValidD <= 1'b0;
    else if (!StallD) instrValidD <= InstrValid;
  end

  always_ff @(posedge clk) begin
    if (!StallD && InstrValid) instrD <= Instr;
  end

  instrDecode decode_i (.Instr(instrD), .InstrValid(instrValidD), .Ctrl(ctrlD));

  regFile regs_i (
    .clk(clk), .We(wbW.regWrite), .Ra1(ctrlD.rs1), .Ra2(ctrlD.rs2),
    .Wa(wbW.rd), .Wd(wbW.result), .Rd1(rd1D), .Rd2(rd2D)
  );

  hazardUnit hazard_i (
    .Rs1D(ctrlD.rs1), .Rs2D(ctrlD.rs2), .Rs1E(exE.ctrl.rs1), .Rs2E(exE.ctrl.rs2),
    .RdE(exE.ctrl.rd), .RdM(memM.rd), .RdW(wbW.rd), .MemReadE(exE.ctrl.memRead),
    .RegWriteM(memM.regWrite), .RegWriteW(wbW.regWrite),
    .ForwardAE(forwardAE), .ForwardBE(forwardBE), .LoadStallD(StallD)
  );

  assign exD = '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D};

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  // A stall turns the Execute slot into a bubble by dropping its enables
  always_ff @(posedge clk) begin
    exE <= exD;
    if (rst || StallD) begin
      exE.ctrl.regWrite <= 1'b0;
      exE.ctrl.memRead <= 1'b0;
      exE.ctrl.memWrite <= 1'b0;
    end
  end

  assign srcAE = fwdMux(forwardAE, exE.rd1, memM.aluResult, wbW.result);
  assign fwdBE = fwdMux(forwardBE, exE.rd2, memM.aluResult, wbW.result);
  // ADDI, LW and SW all add the immediate to rs1
  assign srcBE = exE.ctrl.useImm ? exE.ctrl.imm : fwdBE;

  intAlu alu_i (.A(srcAE), .B(srcBE), .AluOp(exE.ctrl.aluOp), .Y(aluResultE));

  // Store data is the bypassed rs2 rather than the immediate path
  assign memE = '{
    regWrite: exE.ctrl.regWrite, memRead: exE.ctrl.memRead, memWrite: exE.ctrl.memWrite,
    rd: exE.ctrl.rd, aluResult: aluResultE, storeData: fwdBE
  };

  ////////////////////////////////////////////////////////////////////////////
  // Memory and Writeback
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    memM <= memE;
    if (rst) begin
      memM.regWrite <= 1'b0;
      memM.memRead <= 1'b0;
      memM.memWrite <= 1'b0;
    end
  end

  dataMem dmem_i (
    .clk(clk), .We(memM.memWrite), .Addr(memM.aluResult),
    .Wd(memM.storeData), .Rd(readDataM)
  );

  assign wbM = '{
    regWrite: memM.regWrite, rd: memM.rd,
    result: memM.memRead ? readDataM : memM.aluResult
  };

  always_ff @(posedge clk) begin
    wbW <= wbM;
    if (rst) wbW.regWrite <= 1'b0;
  end

  // Retirement view straight from the Writeback register
  assign RegWriteW = wbW.regWrite;
  assign RdW = wbW.rd;
  assign ResultW = wbW.result;

  // A load-use stall lasts one cycle because the bubble it leaves clears the match
  aStallOneCycle: assert property (@(posedge clk) disable iff (rst) StallD |=> !StallD)
    else $error("Decode stalled for more than one cycle");

endmodule

`default_nettype wire

// ==== design/pipePkg.sv ====
`default_nettype none

package pipePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen = 32;
  localparam int regAddrW = 5;
  localparam int memWords = 64;
  // Word index bits taken from the byte address
  localparam int memAddrW = $clog2(memWords);

  // Major opcodes of the supported subset
  localparam logic [6:0] opOp    = 7'b0110011;
  localparam logic [6:0] opOpImm = 7'b0010011;
  localparam logic [6:0] opLoad  = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;

  // funct3 values, the word size of LW/SW shares its code with SLT
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Slt    = 3'b010;
  localparam logic [2:0] f3Xor    = 3'b100;
  localparam logic [2:0] f3Or     = 3'b110;
  localparam logic [2:0] f3And    = 3'b111;
  localparam logic [2:0] f3Word   = 3'b010;

  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Sub  = 7'b0100000;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOpT;

  // Bypass select, encoded like the classic forward block
  typedef enum logic [1:0] {fwdNone = 2'b00, fwdW = 2'b01, fwdM = 2'b10} fwdSelT;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0]          funct7;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rs1;
    logic [2:0]          funct3;
    logic [regAddrW-1:0] rd;
    logic [6:0]          opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0]         imm12;
    logic [regAddrW-1:0] rs1;
    logic [2:0]          funct3;
    logic [regAddrW-1:0] rd;
    logic [6:0]          opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0]          immHi;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rs1;
    logic [2:0]          funct3;
    logic [4:0]          immLo;
    logic [6:0]          opcode;
  } sTypeT;

  // One 32-bit word, read through whichever format the opcode calls for
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    sTypeT sType;
  } instrU;

  ////////////////////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic                useImm;
    aluOpT               aluOp;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [xlen-1:0]     imm;
  } decCtrlT;

  typedef struct packed {
    decCtrlT         ctrl;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
  } exStageT;

  typedef struct packed {
    logic                regWrite;
    logic                memRead;
    logic                memWrite;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     storeData;
  } memStageT;

  typedef struct packed {
    logic                regWrite;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     result;
  } wbStageT;

endpackage

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile import pipePkg::*; (
  input  logic                clk,
  input  logic                We,
  input  logic [regAddrW-1:0] Ra1,
  input  logic [regAddrW-1:0] Ra2,
  input  logic [regAddrW-1:0] Wa,
  input  logic [xlen-1:0]     Wd,
  output logic [xlen-1:0]     Rd1,
  output logic [xlen-1:0]     Rd2
);

  // x0 has no storage behind it
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (We && (Wa != '0)) begin
      regs[Wa] <= Wd;
    end
  end

  // A read that hits the register being written this cycle sees the new value,
  // this closes the Writeback to Decode gap
  function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
    logic [xlen-1:0] val;
    if (addr == '0) val = '0;
    else if (We && (Wa == addr)) val = Wd;
    else val = regs[addr];
    return val;
  endfunction

  always_comb begin
    Rd1 = readPort(Ra1);
    Rd2 = readPort(Ra2);
  end

endmodule

`default_nettype wire

// ==== dv/intPipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module intPipeTb import pipePkg::*;;

  localparam int numTests = 5;
  localparam int resetCycles = 10;
  // Slack per test for the pipeline to empty after its last instruction
  localparam int drainCycles = 20;

  logic                clk = 1'b0;
  logic                rst;
  instrU               Instr;
  logic                InstrValid;
  logic                StallD;
  logic                RegWriteW;
  logic [regAddrW-1:0] RdW;
  logic [xlen-1:0]     ResultW;

  // Program table holding an instruction word and its test number per entry
  logic [31:0] progWord [$];
  int          progTest [$];
  string       testNames [numTests] = '{"memory forwarding", "writeback forwarding priority",
                                        "load use stall", "x0 writes", "store load and logic"};

  // Reference state and predicted retirements
  logic [xlen-1:0]     refRegs [32];
  logic [xlen-1:0]     refMem [memWords];
  logic [regAddrW-1:0] expRdQ [$];
  logic [xlen-1:0]     expValQ [$];

  int seed;
  int predicted = 0;
  int checks = 0;
  int errors = 0;
  int curTest = 0;
  int cycleCount = 0;
  int cycleLimit = 100000;
  bit stallSeen;

  intPipe dut_i (
    .clk(clk), .rst(rst), .Instr(Instr), .InstrValid(InstrValid), .StallD(StallD),
    .RegWriteW(RegWriteW), .RdW(RdW), .ResultW(ResultW)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encoding straight from the RV32I formats
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                       input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opOp};
  endfunction

  function automatic logic [31:0] encAddi(input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), 3'b000, 5'(rd), opOpImm};
  endfunction

  function automatic logic [31:0] encLw(input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), 3'b010, 5'(rd), opLoad};
  endfunction

  function automatic logic [31:0] encSw(input int rs2, input int rs1, input logic [11:0] imm);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], opStore};
  endfunction

  function automatic logic [11:0] nextImm();
    int r;
    r = $random(seed);
    return r[11:0];
  endfunction

  task automatic addEntry(input int t, input logic [31:0] w);
    progWord.push_back(w);
    progTest.push_back(t);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model taking one architectural step per table entry
  ////////////////////////////////////////////////////////////////////////////

  task automatic modelStep(input logic [31:0] w);
    logic [6:0]          op;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     a;
    logic [xlen-1:0]     b;
    logic [xlen-1:0]     immI;
    logic [xlen-1:0]     immS;
    logic [xlen-1:0]     res;
    bit                  writes;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    rd = w[11:7];
    a = refRegs[w[19:15]];
    b = refRegs[w[24:20]];
    immI = {{20{w[31]}}, w[31:20]};
    immS = {{20{w[31]}}, w[31:25], w[11:7]};
    writes = 1'b1;
    res = '0;
    if (op == opOp && f7 == 7'b0100000 && f3 == 3'b000) res = a - b;
    else if (op == opOp && f3 == 3'b000) res = a + b;
    else if (op == opOp && f3 == 3'b010) res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    else if (op == opOp && f3 == 3'b100) res = a ^ b;
    else if (op == opOp && f3 == 3'b110) res = a | b;
    else if (op == opOp && f3 == 3'b111) res = a & b;
    else if (op == opOpImm) res = a + immI;
    else if (op == opLoad) res = refMem[((a + immI) >> 2) % memWords];
    else begin
      // Stores change memory only and retire without a register write
      if (op == opStore) refMem[((a + immS) >> 2) % memWords] = b;
      writes = 1'b0;
    end
    if (writes) begin
      // A write to x0 still retires but leaves x0 at zero
      expRdQ.push_back(rd);
      expValQ.push_back(res);
      predicted++;
      if (rd != 0) refRegs[rd] = res;
    end
  endtask

  task automatic buildProgram();
    // Back-to-back dependent ALU ops through the Memory bypass
    addEntry(0, encAddi(1, 0, nextImm()));
    addEntry(0, encAddi(2, 0, nextImm()));
    addEntry(0, encR(7'b0000000, 3'b000, 3, 1, 2));
    addEntry(0, encR(7'b0100000, 3'b000, 4, 3, 1));
    addEntry(0, encR(7'b0000000, 3'b000, 5, 4, 3));
    // A use two apart takes Writeback and then x11 sits in both Memory and Writeback
    addEntry(1, encAddi(6, 0, nextImm()));
    addEntry(1, encAddi(7, 0, nextImm()));
    addEntry(1, encR(7'b0000000, 3'b000, 8, 6, 7));
    addEntry(1, encAddi(9, 0, 12'd1));
    addEntry(1, encR(7'b0000000, 3'b000, 10, 8, 6));
    addEntry(1, encAddi(11, 0, nextImm()));
    addEntry(1, encAddi(11, 0, nextImm()));
    addEntry(1, encR(7'b0000000, 3'b000, 12, 11, 11));
    // Load followed directly by a use on rs1 and then on rs2
    addEntry(2, encAddi(13, 0, nextImm()));
    addEntry(2, encSw(13, 0, 12'd8));
    addEntry(2, encLw(14, 0, 12'd8));
    addEntry(2, encR(7'b0000000, 3'b000, 15, 14, 13));
    addEntry(2, encLw(16, 0, 12'd8));
    addEntry(2, encR(7'b0100000, 3'b000, 17, 1, 16));
    // Writes into x0 and then x0 read as an operand
    addEntry(3, encAddi(0, 0, nextImm()));
    addEntry(3, encR(7'b0000000, 3'b000, 0, 1, 2));
    addEntry(3, encR(7'b0000000, 3'b000, 18, 0, 1));
    // Random words through memory and then the logic ops and signed compare
    addEntry(4, encAddi(19, 0, nextImm()));
    addEntry(4, encAddi(20, 0, nextImm()));
    addEntry(4, encSw(19, 0, 12'd16));
    addEntry(4, encSw(20, 0, 12'd20));
    addEntry(4, encLw(21, 0, 12'd16));
    addEntry(4, encLw(22, 0, 12'd20));
    addEntry(4, encR(7'b0000000, 3'b111, 23, 19, 20));
    addEntry(4, encR(7'b0000000, 3'b110, 24, 19, 20));
    addEntry(4, encR(7'b0000000, 3'b100, 25, 19, 20));
    addEntry(4, encR(7'b0000000, 3'b010, 26, 19, 20));
    addEntry(4, encR(7'b0000000, 3'b010, 27, 20, 19));
  endtask

  // Present one word and keep it steady until Decode is free to take it
  task automatic applyInstr(input logic [31:0] w);
    @(negedge clk);
    Instr = w;
    InstrValid = 1'b1;
    while (StallD) begin
      stallSeen = 1'b1;
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Retirement checker and timeout
  ////////////////////////////////////////////////////////////////////////////

  // Writeback outputs change only at the rising edge
  always @(negedge clk) begin
    if (!rst && RegWriteW) begin
      if (expRdQ.size() == 0) begin
        $display("test %0d: retirement to x%0d arrived with nothing left to expect", curTest, RdW);
        errors++;
      end else begin
        if (RdW !== expRdQ[0] || ResultW !== expValQ[0]) begin
          $display("error at %0t: expected x%0d = %h, got x%0d = %h",
                   $time, expRdQ[0], expValQ[0], RdW, ResultW);
          errors++;
        end
        void'(expRdQ.pop_front());
        void'(expValQ.pop_front());
      end
      checks++;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("timeout: test %0d (%s) did not finish within %0d cycles",
               curTest, testNames[curTest], cycleLimit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int errStart;
    rst = 1'b1;
    Instr = '0;
    InstrValid = 1'b0;
    seed = 32'hd243_3dba;
    foreach (refRegs[i]) refRegs[i] = '0;
    foreach (refMem[i]) refMem[i] = '0;
    buildProgram();
    // Worst case is a stall on every entry plus reset and the drains
    cycleLimit = 4 * progWord.size() + resetCycles + drainCycles * numTests;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int t = 0; t < numTests; t++) begin
      curTest = t;
      errStart = errors;
      stallSeen = 1'b0;
      for (int i = 0; i < progWord.size(); i++) begin
        if (progTest[i] == t) begin
          modelStep(progWord[i]);
          applyInstr(progWord[i]);
        end
      end
      @(negedge clk);
      InstrValid = 1'b0;
      while (checks < predicted) @(negedge clk);
      // The load-use group has to have held Decode at least once
      if (t == 2 && !stallSeen) begin
        $display("test %0d: StallD never went high during the load use sequence", t);
        errors++;
      end
      $display("test %0d (%s) finished with %0d errors", t, testNames[t], errors - errStart);
    end
    $display("tests %0d, retirements checked %0d, errors %0d", numTests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
design/pipePkg.sv
design/instrDecode.sv
design/regFile.sv
design/intAlu.sv
design/hazardUnit.sv
design/dataMem.sv
design/intPipe.sv
dv/intPipeTb.sv
